//--- common/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// ######################################################################
// Router link widths
// ######################################################################

// Port count is tied to the one-hot arbiter state, so it stays at five
`define ROUTER_PORTS 5

// Bits per flit on every input and on the output link
`define FLIT_WIDTH 16

// Bits of the tenure length carried in a head flit
`define LEN_WIDTH 12

`endif

//--- common/routerPkg.sv
`include "router_config.svh"

package routerPkg;

  // ######################################################################
  // Flit encoding
  // ######################################################################

  typedef enum logic [2:0]
  {
    headFlit = 3'd1,
    bodyFlit = 3'd2,
    tailFlit = 3'd4
  } flitKind;

  // Header view of a flit word with the length in the low bits
  typedef struct packed
  {
    logic [`FLIT_WIDTH-`LEN_WIDTH-1:0] reserved;
    logic [`LEN_WIDTH-1:0]             length;
  } flitHeader;

  // The flit kind selects which view applies
  typedef union packed
  {
    flitHeader               header;
    logic [`FLIT_WIDTH-1:0]  body;
  } flitWord;

  // ######################################################################
  // Ports and arbitration
  // ######################################################################

  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIndex;

  // One-hot state where bit 0 is idle and bit n+1 grants port n
  typedef enum logic [`ROUTER_PORTS:0]
  {
    arbIdle = 6'b000001,
    arbL    = 6'b000010,
    arbN    = 6'b000100,
    arbE    = 6'b001000,
    arbW    = 6'b010000,
    arbS    = 6'b100000
  } arbState;

endpackage

//--- common/portReqIf.sv
`include "router_config.svh"

// One port's slot as seen by the arbiter and the output stage
interface portReqIf;

  logic                   req;
  logic                   full;
  routerPkg::flitKind     kind;
  logic [`LEN_WIDTH-1:0]  length;
  routerPkg::flitWord     flit;
  logic                   take;

  modport inStage
  (
    output req, full, kind, length, flit,
    input  take
  );

  modport arbiter
  (
    input req, full, kind, length
  );

  modport outStage
  (
    input  full, kind, flit,
    output take
  );

endinterface

//--- verilog/inputStage.sv
`include "router_config.svh"

module inputStage
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  routerPkg::flitKind inKind,
  input  routerPkg::flitWord inFlit,
  output logic               busy,
  portReqIf.inStage          port
);

  logic                  slotFull;
  logic                  pktOpen;
  logic                  accept;
  routerPkg::flitKind    slotKind;
  routerPkg::flitWord    slotFlit;
  logic [`LEN_WIDTH-1:0] pktLength;

  // A flit offered while the slot is occupied is dropped
  assign accept = inValid && !slotFull;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slotFull <= 1'b0;
      pktOpen  <= 1'b0;
    end
    else
    begin
      if (accept)
        slotFull <= 1'b1;
      else if (port.take)
        slotFull <= 1'b0;

      if (accept && inKind == routerPkg::headFlit)
        pktOpen <= 1'b1;
      else if (port.take && slotKind == routerPkg::tailFlit)
        pktOpen <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      slotKind <= inKind;
      slotFlit <= inFlit;
    end
    // Length stays put until the next head flit
    if (accept && inKind == routerPkg::headFlit)
      pktLength <= inFlit.header.length;
  end

  assign busy        = slotFull;
  assign port.full   = slotFull;
  assign port.req    = slotFull || pktOpen;
  assign port.kind   = slotKind;
  assign port.flit   = slotFlit;
  assign port.length = pktLength;

endmodule

//--- arbiter/tenureTimer.sv
`include "router_config.svh"

module tenureTimer
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [`LEN_WIDTH-1:0] length,
  input  logic                  run,
  output logic                  timesUp
);

  logic [`LEN_WIDTH-1:0] limit;
  logic [`LEN_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= length;
      // Count only the cycles the port keeps its grant
      count <= run ? count + 1'b1 : '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- arbiter/switchArbiter.sv
`include "router_config.svh"

module switchArbiter
(
  input  logic                clk,
  input  logic                rst,
  portReqIf.arbiter           ports [`ROUTER_PORTS],
  output routerPkg::arbState  state
);

  logic [`ROUTER_PORTS-1:0] reqVec;
  logic [`ROUTER_PORTS-1:0] timesUp;
  logic [`ROUTER_PORTS-1:0] runVec;
  routerPkg::arbState       nextState;

  function automatic routerPkg::arbState portState(input int idx);
    return routerPkg::arbState'(6'b000010 << idx);
  endfunction

  // ######################################################################
  // Per-port request gathering and tenure timers
  // ######################################################################

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genPort
    logic load;

    assign reqVec[i] = ports[i].req;
    // Length is latched while a head flit waits in the slot
    assign load = ports[i].full && ports[i].kind == routerPkg::headFlit;

    tenureTimer timerInst
    (
      .clk     (clk),
      .rst     (rst),
      .load    (load),
      .length  (ports[i].length),
      .run     (runVec[i]),
      .timesUp (timesUp[i])
    );
  end

  // ######################################################################
  // Allocation state machine
  // ######################################################################

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= routerPkg::arbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    int cur;
    int idx;

    cur       = 0;
    idx       = 0;
    runVec    = '0;
    nextState = routerPkg::arbIdle;

    if (state == routerPkg::arbIdle)
    begin
      // Walk backwards so the lowest requesting port wins
      for (int i = `ROUTER_PORTS - 1; i >= 0; i--)
        if (reqVec[i])
          nextState = portState(i);
    end
    else
    begin
      for (int i = 0; i < `ROUTER_PORTS; i++)
        if (state[i+1])
          cur = i;

      if (reqVec[cur] && !timesUp[cur])
      begin
        runVec[cur] = 1'b1;
        nextState   = state;
      end
      else
      begin
        // Rotating order starts just after the current port and skips it
        for (int k = `ROUTER_PORTS - 1; k >= 1; k--)
        begin
          idx = (cur + k) % `ROUTER_PORTS;
          if (reqVec[idx])
            nextState = portState(idx);
        end
      end
    end
  end

endmodule

//--- verilog/linkOutputStage.sv
`include "router_config.svh"

module linkOutputStage
(
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::arbState  state,
  portReqIf.outStage          ports [`ROUTER_PORTS],
  output logic                outValid,
  output routerPkg::portIndex outPort,
  output routerPkg::flitKind  outKind,
  output routerPkg::flitWord  outFlit
);

  logic [`ROUTER_PORTS-1:0] takeVec;
  routerPkg::flitKind       kindArr [`ROUTER_PORTS];
  routerPkg::flitWord       flitArr [`ROUTER_PORTS];
  routerPkg::portIndex      selPort;

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genPort
    assign kindArr[i]    = ports[i].kind;
    assign flitArr[i]    = ports[i].flit;
    // Granted port with a flit waiting gives it up this cycle
    assign takeVec[i]    = state[i+1] && ports[i].full;
    assign ports[i].take = takeVec[i];
  end

  always_comb
  begin
    selPort = routerPkg::portL;
    for (int i = 0; i < `ROUTER_PORTS; i++)
      if (state[i+1])
        selPort = routerPkg::portIndex'(i);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |takeVec;
  end

  always_ff @(posedge clk)
  begin
    if (|takeVec)
    begin
      outPort <= selPort;
      outKind <= kindArr[selPort];
      outFlit <= flitArr[selPort];
    end
  end

endmodule

//--- verilog/routerLinkTop.sv
`include "router_config.svh"

module routerLinkTop
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`ROUTER_PORTS-1:0]  inValid,
  input  routerPkg::flitKind        inKind [`ROUTER_PORTS],
  input  routerPkg::flitWord        inFlit [`ROUTER_PORTS],
  output logic [`ROUTER_PORTS-1:0]  busy,
  output logic                      outValid,
  output routerPkg::portIndex       outPort,
  output routerPkg::flitKind        outKind,
  output routerPkg::flitWord        outFlit,
  output routerPkg::arbState        grant
);

  // ######################################################################
  // One input slot per port
  // ######################################################################

  portReqIf ports [`ROUTER_PORTS] ();

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genStage
    inputStage stageInst
    (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inKind  (inKind[i]),
      .inFlit  (inFlit[i]),
      .busy    (busy[i]),
      .port    (ports[i])
    );
  end

  // ######################################################################
  // Switch allocation and output link
  // ######################################################################

  switchArbiter arbiterInst
  (
    .clk   (clk),
    .rst   (rst),
    .ports (ports),
    .state (grant)
  );

  // The output stage follows the registered grant
  linkOutputStage outInst
  (
    .clk      (clk),
    .rst      (rst),
    .state    (grant),
    .ports    (ports),
    .outValid (outValid),
    .outPort  (outPort),
    .outKind  (outKind),
    .outFlit  (outFlit)
  );

endmodule

//--- testbench/tbRouterLink.sv
`include "router_config.svh"

module tbRouterLink;

  localparam int entryWidth = `FLIT_WIDTH + 3;
  // The five tests send 5, 15, 15, 9 and 8 flits in turn
  localparam int totalFlits = 52;
  localparam int cycleLimit = 40 * totalFlits;

  logic                      clk;
  logic                      rst;
  logic [`ROUTER_PORTS-1:0]  inValid;
  routerPkg::flitKind        inKind [`ROUTER_PORTS];
  routerPkg::flitWord        inFlit [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]  busy;
  logic                      outValid;
  routerPkg::portIndex       outPort;
  routerPkg::flitKind        outKind;
  routerPkg::flitWord        outFlit;
  routerPkg::arbState        grant;

  // The scoreboard keeps one queue of {kind, flit} per input port
  logic [entryWidth-1:0] expQ [`ROUTER_PORTS][$];
  int    outLog[$];
  int    expOrder[$];
  string testName;
  int    errorCount;
  int    errorsAtStart;
  int    checkCount;
  int    sentCount;
  int    testCount;
  int    cycleCount;

  routerLinkTop dut_i
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inKind   (inKind),
    .inFlit   (inFlit),
    .busy     (busy),
    .outValid (outValid),
    .outPort  (outPort),
    .outKind  (outKind),
    .outFlit  (outFlit),
    .grant    (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ######################################################################
  // Helpers
  // ######################################################################

  task automatic reportMismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("MISMATCH %s %s expected %0h actual %0h", testName, what, expected, actual);
    errorCount++;
  endtask

  task automatic waitCycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic int pendingFlits();
    int n;
    n = 0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
      n += expQ[p].size();
    return n;
  endfunction

  // Head carries the tenure length and the other flits carry random payload
  task automatic sendPacket(input int p, input int nBody, input logic [`LEN_WIDTH-1:0] len);
    routerPkg::flitKind kind;
    routerPkg::flitWord word;
    int                 total;
    int                 j;
    total = nBody + 2;
    for (j = 0; j < total; j++)
    begin
      if (j == 0)
      begin
        kind                = routerPkg::headFlit;
        word.header.reserved = '0;
        word.header.length   = len;
      end
      else
      begin
        kind      = (j == total - 1) ? routerPkg::tailFlit : routerPkg::bodyFlit;
        word.body = 16'($urandom());
      end
      while (busy[p])
        waitCycles(1);
      inValid[p] = 1'b1;
      inKind[p]  = kind;
      inFlit[p]  = word;
      expQ[p].push_back({kind, word});
      sentCount++;
      waitCycles(1);
      inValid[p] = 1'b0;
    end
  endtask

  // Collapse the output log into runs of one port and compare with the expected order
  task automatic checkOrder();
    int groups[$];
    int last;
    int i;
    last = -1;
    for (i = 0; i < outLog.size(); i++)
      if (outLog[i] != last)
      begin
        groups.push_back(outLog[i]);
        last = outLog[i];
      end
    checkCount++;
    assert (groups.size() == expOrder.size())
    else
      reportMismatch("grant run count", 32'(expOrder.size()), 32'(groups.size()));
    for (i = 0; i < groups.size() && i < expOrder.size(); i++)
      assert (groups[i] == expOrder[i])
      else
        reportMismatch($sformatf("grant run %0d", i), 32'(expOrder[i]), 32'(groups[i]));
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
    outLog.delete();
  endtask

  task automatic finishTest();
    while (pendingFlits() != 0)
      @(posedge clk);
    waitCycles(3);
    checkCount++;
    assert (grant == routerPkg::arbIdle)
    else
      reportMismatch("grant after drain", 32'(routerPkg::arbIdle), 32'(grant));
    checkOrder();
    $display("%s finished: %0d flits out, %0d errors", testName, outLog.size(),
             errorCount - errorsAtStart);
    testCount++;
  endtask

  // ######################################################################
  // Output monitor that samples mid-cycle
  // ######################################################################

  always @(negedge clk)
  begin : monitor
    int                    p;
    logic                  known;
    logic [entryWidth-1:0] expected;
    if (!rst && outValid)
    begin
      p     = int'(outPort);
      known = 1'b0;
      if (p < `ROUTER_PORTS)
        known = (expQ[p].size() > 0);
      outLog.push_back(p);
      checkCount++;
      assert (known)
      else
      begin
        $display("%s: output flit tagged with port %0d, which has no flit outstanding",
                 testName, p);
        errorCount++;
      end
      if (known)
      begin
        expected = expQ[p].pop_front();
        assert ({outKind, outFlit} == expected)
        else
          reportMismatch($sformatf("port %0d flit", p), 32'(expected),
                         32'({outKind, outFlit}));
      end
    end
  end

  initial
  begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

  // ######################################################################
  // Test sequence
  // ######################################################################

  initial
  begin
    void'($urandom(32'h3a83_5196));
    errorCount = 0;
    checkCount = 0;
    sentCount  = 0;
    testCount  = 0;
    rst        = 1'b1;
    inValid    = '0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
    begin
      inKind[p] = routerPkg::bodyFlit;
      inFlit[p] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    startTest("resetIdle");
    repeat (3)
    begin
      @(negedge clk);
      checkCount++;
      assert (outValid == 1'b0) else reportMismatch("outValid", 32'd0, 32'(outValid));
      assert (busy == '0) else reportMismatch("busy", 32'd0, 32'(busy));
      assert (grant == routerPkg::arbIdle)
      else
        reportMismatch("grant", 32'(routerPkg::arbIdle), 32'(grant));
    end
    waitCycles(1);
    expOrder = {};
    finishTest();

    startTest("singlePacket");
    expOrder = '{1};
    sendPacket(1, 3, 12'd100);
    finishTest();

    // All heads land in the same cycle while the arbiter is idle
    startTest("simultaneousHeads");
    expOrder = '{0, 1, 2, 3, 4};
    fork
      sendPacket(0, 1, 12'd100);
      sendPacket(1, 1, 12'd100);
      sendPacket(2, 1, 12'd100);
      sendPacket(3, 1, 12'd100);
      sendPacket(4, 1, 12'd100);
    join
    finishTest();

    // East holds the link while L, W and S queue up behind it
    startTest("rotatingGrant");
    expOrder = '{2, 3, 4, 0};
    fork
      sendPacket(2, 4, 12'd100);
      begin
        waitCycles(3);
        sendPacket(0, 1, 12'd100);
      end
      begin
        waitCycles(3);
        sendPacket(3, 1, 12'd100);
      end
      begin
        waitCycles(3);
        sendPacket(4, 1, 12'd100);
      end
    join
    finishTest();

    startTest("longTenure");
    expOrder = '{0, 1};
    fork
      sendPacket(0, 3, 12'd40);
      sendPacket(1, 2, 12'd100);
    join
    finishTest();

    // Tenure of 2 lets North in after L's first body flit
    startTest("shortTenure");
    expOrder = '{0, 1, 0};
    fork
      sendPacket(0, 2, 12'd2);
      sendPacket(1, 2, 12'd100);
    join
    finishTest();

    $display("%0d tests, %0d flits sent, %0d checks, %0d errors", testCount, sentCount,
             checkCount, errorCount);
    if (errorCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/routerPkg.sv
common/portReqIf.sv
verilog/inputStage.sv
arbiter/tenureTimer.sv
arbiter/switchArbiter.sv
verilog/linkOutputStage.sv
verilog/routerLinkTop.sv
testbench/tbRouterLink.sv

//--- run.sh
#!/bin/sh
# Compile the router link testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbRouterLink -o simRouterLink

simOut=$(./obj_dir/simRouterLink)
echo "$simOut"

if echo "$simOut" | grep -qxF "=== PASS ==="; then
  exit 0
fi
exit 1
